// File: Bender.yml
package:
  name: cache

sources:
  - logic/cache_pkg.sv
  - logic/tag_store.sv
  - logic/data_store.sv
  - logic/cache_ctrl.sv
  - logic/cache_top.sv
  - target: test
    files:
      - testbench/cache_tb.sv

// File: logic/cache_ctrl.sv
module cache_ctrl #(
  parameter int IDX_BITS = 4,
  localparam int TAG_BITS = cache_pkg::ADDR_BITS - IDX_BITS
                            - cache_pkg::OFFSET_BITS - cache_pkg::BYTE_BITS
) (
  input  logic                clk,
  input  logic                reset,
  // processor side
  input  cache_pkg::addr_t    a,
  input  cache_pkg::be_t      be,
  input  logic                read,
  input  logic                write,
  input  cache_pkg::word_t    wd,
  output logic                ready,
  output logic                rd_valid,
  output cache_pkg::word_t    rd,
  // registered request to both stores
  output logic [IDX_BITS-1:0] index,
  output logic [TAG_BITS-1:0] req_tag,
  output cache_pkg::offset_t  req_offset,
  output cache_pkg::be_t      req_be,
  output cache_pkg::word_t    req_wd,
  // tag store results
  input  cache_pkg::way_t     hit_way,
  input  cache_pkg::way_t     victim_way,
  input  logic                victim_dirty,
  input  logic [TAG_BITS-1:0] victim_tag,
  // data store results
  input  cache_pkg::word_t    hit_word,
  input  cache_pkg::word_t    fill_word,
  // store strobes
  output cache_pkg::way_t     tag_write,
  output cache_pkg::way_t     word_write,
  output cache_pkg::way_t     fill_write,
  output logic                hit_update,
  output logic                dirty_set,
  output logic                fill_merge,
  // memory side
  output cache_pkg::addr_t    mm_a,
  output logic                mm_read,
  output logic                mm_write,
  input  logic                mm_ready,
  input  logic                mm_readdata_valid
);

  import cache_pkg::*;

  localparam int LINE_OFS = OFFSET_BITS + BYTE_BITS;

  ctrl_state_e state;
  ctrl_state_e state_next;

  logic accept;
  // second lookup cycle, compare results registered
  logic lookup_done;
  logic req_write;
  logic rd_valid_next;
  way_t hit_way_q;
  logic victim_dirty_q;

  assign ready = (state == IDLE);
  assign accept = ready && (read || write);

  // --------------------------------------
  // request register
  // --------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      req_tag <= a[ADDR_BITS-1 -: TAG_BITS];
      index <= a[LINE_OFS +: IDX_BITS];
      req_offset <= a[BYTE_BITS +: OFFSET_BITS];
      req_be <= be;
      req_wd <= wd;
    end
    // compare results from the first lookup cycle
    if (state == LOOKUP && !lookup_done) begin
      hit_way_q <= hit_way;
      victim_dirty_q <= victim_dirty;
    end
    // read data, hit word or word of the returned line
    if (state == LOOKUP && lookup_done && (|hit_way_q) && !req_write) begin
      rd <= hit_word;
    end else if (state == FILL_WAIT && mm_readdata_valid && !req_write) begin
      rd <= fill_word;
    end
  end

  // --------------------------------------
  // state and control flops
  // --------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      lookup_done <= 1'b0;
      req_write <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      state <= state_next;
      lookup_done <= (state == LOOKUP) && !lookup_done;
      rd_valid <= rd_valid_next;
      if (accept) begin
        req_write <= write;
      end
    end
  end

  // --------------------------------------
  // next state and strobes
  // --------------------------------------
  always_comb begin
    state_next = state;
    rd_valid_next = 1'b0;
    tag_write = '0;
    word_write = '0;
    fill_write = '0;
    hit_update = 1'b0;
    dirty_set = 1'b0;
    fill_merge = 1'b0;
    mm_read = 1'b0;
    mm_write = 1'b0;
    // line address of the request by default
    mm_a = {req_tag, index, {LINE_OFS{1'b0}}};
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = LOOKUP;
        end
      end
      LOOKUP: begin
        if (lookup_done) begin
          if (|hit_way_q) begin
            hit_update = 1'b1;
            dirty_set = req_write;
            word_write = req_write ? hit_way_q : '0;
            rd_valid_next = !req_write;
            state_next = IDLE;
          end else if (victim_dirty_q) begin
            state_next = EVICT;
          end else begin
            state_next = FILL_REQ;
          end
        end
      end
      EVICT: begin
        // victim line goes to its own address
        mm_a = {victim_tag, index, {LINE_OFS{1'b0}}};
        if (mm_ready) begin
          mm_write = 1'b1;
          state_next = FILL_REQ;
        end
      end
      FILL_REQ: begin
        if (mm_ready) begin
          mm_read = 1'b1;
          state_next = FILL_WAIT;
        end
      end
      FILL_WAIT: begin
        // line only valid with the pulse, store it now
        if (mm_readdata_valid) begin
          fill_write = victim_way;
          fill_merge = req_write;
          state_next = FILL_WRITE;
        end
      end
      FILL_WRITE: begin
        tag_write = victim_way;
        dirty_set = req_write;
        rd_valid_next = !req_write;
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // --------------------------------------
  // checks
  // --------------------------------------
  a_mm_excl : assert property (@(posedge clk) disable iff (reset)
    !(mm_read && mm_write));

  a_mm_ready : assert property (@(posedge clk) disable iff (reset)
    (mm_read || mm_write) |-> mm_ready);

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

  // --------------------------------------
  // address and data widths
  // --------------------------------------
  // byte address
  localparam int ADDR_BITS = 32;
  // processor data word
  localparam int WORD_BITS = 32;
  // words per cache line
  localparam int LINE_WORDS = 8;
  localparam int LINE_BITS = LINE_WORDS * WORD_BITS;
  // word select inside a line
  localparam int OFFSET_BITS = 3;
  // byte bits below the word, not used for lookup
  localparam int BYTE_BITS = 2;

  // two ways only, one lru bit per set
  localparam int WAYS = 2;

  // --------------------------------------
  // data types
  // --------------------------------------
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [LINE_BITS-1:0] line_t;
  typedef logic [WORD_BITS/8-1:0] be_t;
  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [OFFSET_BITS-1:0] offset_t;
  // one-hot way select
  typedef logic [WAYS-1:0] way_t;

  // --------------------------------------
  // controller states
  // --------------------------------------
  typedef enum logic [2:0] {
    // waiting for a request, ready high
    IDLE,
    // tag compare, then hit service or miss dispatch
    LOOKUP,
    // dirty victim goes out to memory
    EVICT,
    // line read command
    FILL_REQ,
    // wait for returned line, data array written here
    FILL_WAIT,
    // tag, valid, dirty and lru update for the filled way
    FILL_WRITE
  } ctrl_state_e;

endpackage

// File: logic/cache_top.sv
module cache_top #(
  parameter int IDX_BITS = 4
) (
  input  logic               clk,
  input  logic               reset,
  input  cache_pkg::addr_t   a,
  input  cache_pkg::be_t     be,
  input  logic               read,
  input  logic               write,
  input  cache_pkg::word_t   wd,
  output cache_pkg::word_t   rd,
  output logic               rd_valid,
  output logic               ready,
  output cache_pkg::addr_t   mm_a,
  output logic               mm_read,
  output logic               mm_write,
  output cache_pkg::line_t   mm_writedata,
  input  cache_pkg::line_t   mm_readdata,
  input  logic               mm_readdata_valid,
  input  logic               mm_ready
);

  import cache_pkg::*;

  localparam int TAG_BITS = ADDR_BITS - IDX_BITS - OFFSET_BITS - BYTE_BITS;

  // --------------------------------------
  // request fields from the controller
  // --------------------------------------
  logic [IDX_BITS-1:0] index;
  logic [TAG_BITS-1:0] req_tag;
  offset_t req_offset;
  be_t req_be;
  word_t req_wd;

  // tag store results
  way_t hit_way;
  way_t victim_way;
  logic victim_dirty;
  logic [TAG_BITS-1:0] victim_tag;

  // data store results
  word_t hit_word;
  word_t fill_word;

  // store strobes
  way_t tag_write;
  way_t word_write;
  way_t fill_write;
  logic hit_update;
  logic dirty_set;
  logic fill_merge;

  // --------------------------------------
  // controller
  // --------------------------------------
  cache_ctrl #(
    .IDX_BITS(IDX_BITS)
  ) u_ctrl (
    .clk              (clk),
    .reset            (reset),
    .a                (a),
    .be               (be),
    .read             (read),
    .write            (write),
    .wd               (wd),
    .ready            (ready),
    .rd_valid         (rd_valid),
    .rd               (rd),
    .index            (index),
    .req_tag          (req_tag),
    .req_offset       (req_offset),
    .req_be           (req_be),
    .req_wd           (req_wd),
    .hit_way          (hit_way),
    .victim_way       (victim_way),
    .victim_dirty     (victim_dirty),
    .victim_tag       (victim_tag),
    .hit_word         (hit_word),
    .fill_word        (fill_word),
    .tag_write        (tag_write),
    .word_write       (word_write),
    .fill_write       (fill_write),
    .hit_update       (hit_update),
    .dirty_set        (dirty_set),
    .fill_merge       (fill_merge),
    .mm_a             (mm_a),
    .mm_read          (mm_read),
    .mm_write         (mm_write),
    .mm_ready         (mm_ready),
    .mm_readdata_valid(mm_readdata_valid)
  );

  // --------------------------------------
  // stores, side by side on the same index
  // --------------------------------------
  tag_store #(
    .IDX_BITS(IDX_BITS)
  ) u_tags (
    .clk         (clk),
    .reset       (reset),
    .index       (index),
    .tag         (req_tag),
    .tag_write   (tag_write),
    .hit_update  (hit_update),
    .dirty_set   (dirty_set),
    .hit_way     (hit_way),
    .victim_way  (victim_way),
    .victim_dirty(victim_dirty),
    .victim_tag  (victim_tag)
  );

  // victim line feeds the eviction bus directly
  data_store #(
    .IDX_BITS(IDX_BITS)
  ) u_data (
    .clk        (clk),
    .index      (index),
    .offset     (req_offset),
    .be         (req_be),
    .wd         (req_wd),
    .word_write (word_write),
    .fill_write (fill_write),
    .fill_merge (fill_merge),
    .fill_line  (mm_readdata),
    .hit_way    (hit_way),
    .hit_word   (hit_word),
    .fill_word  (fill_word),
    .victim_way (victim_way),
    .victim_line(mm_writedata)
  );

endmodule

// File: logic/data_store.sv
module data_store #(
  parameter int IDX_BITS = 4
) (
  input  logic                 clk,
  input  logic [IDX_BITS-1:0]  index,
  input  cache_pkg::offset_t   offset,
  input  cache_pkg::be_t       be,
  input  cache_pkg::word_t     wd,
  input  cache_pkg::way_t      word_write,
  input  cache_pkg::way_t      fill_write,
  input  logic                 fill_merge,
  input  cache_pkg::line_t     fill_line,
  input  cache_pkg::way_t      hit_way,
  output cache_pkg::word_t     hit_word,
  output cache_pkg::word_t     fill_word,
  input  cache_pkg::way_t      victim_way,
  output cache_pkg::line_t     victim_line
);

  import cache_pkg::*;

  localparam int SETS = 2 ** IDX_BITS;

  // one line array per way
  line_t mem_q [WAYS][SETS];

  // fill line after the optional write-word overlay
  line_t fill_data;
  // line of the hit way
  line_t hit_line;

  // --------------------------------------
  // write alignment
  // --------------------------------------
  // overlay enabled bytes of a word onto one word slot of a line
  function automatic line_t merge_word(line_t line, offset_t off, be_t wbe, word_t wdat);
    line_t res;
    int b;
    res = line;
    for (b = 0; b < WORD_BITS / 8; b++) begin
      if (wbe[b]) begin
        res[int'(off) * WORD_BITS + b * 8 +: 8] = wdat[b * 8 +: 8];
      end
    end
    return res;
  endfunction

  // write miss merges the store word into the incoming line
  assign fill_data = fill_merge ? merge_word(fill_line, offset, be, wd) : fill_line;

  // --------------------------------------
  // array write
  // --------------------------------------
  always_ff @(posedge clk) begin
    for (int w = 0; w < WAYS; w++) begin
      if (fill_write[w]) begin
        mem_q[w][index] <= fill_data;
      end else if (word_write[w]) begin
        // read-modify-write of the offset word only
        mem_q[w][index] <= merge_word(mem_q[w][index], offset, be, wd);
      end
    end
  end

  // --------------------------------------
  // read side
  // --------------------------------------
  // one-hot way muxes
  always_comb begin
    hit_line = '0;
    victim_line = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (hit_way[w]) begin
        hit_line = mem_q[w][index];
      end
      if (victim_way[w]) begin
        victim_line = mem_q[w][index];
      end
    end
  end

  // word select
  assign hit_word = hit_line[int'(offset) * WORD_BITS +: WORD_BITS];
  // read miss data comes straight from the memory line
  assign fill_word = fill_line[int'(offset) * WORD_BITS +: WORD_BITS];

  // --------------------------------------
  // checks
  // --------------------------------------
  // hit write and fill belong to different controller states
  a_write_excl : assert property (@(posedge clk)
    !((|word_write) && (|fill_write)));

endmodule

// File: logic/tag_store.sv
module tag_store #(
  parameter int IDX_BITS = 4,
  localparam int TAG_BITS = cache_pkg::ADDR_BITS - IDX_BITS
                            - cache_pkg::OFFSET_BITS - cache_pkg::BYTE_BITS
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [IDX_BITS-1:0] index,
  input  logic [TAG_BITS-1:0] tag,
  input  cache_pkg::way_t     tag_write,
  input  logic                hit_update,
  input  logic                dirty_set,
  output cache_pkg::way_t     hit_way,
  output cache_pkg::way_t     victim_way,
  output logic                victim_dirty,
  output logic [TAG_BITS-1:0] victim_tag
);

  import cache_pkg::*;

  localparam int SETS = 2 ** IDX_BITS;

  // --------------------------------------
  // storage
  // --------------------------------------
  // tag array per way
  logic [TAG_BITS-1:0] tag_mem [WAYS][SETS];
  // per-way status, one bit per set
  logic [SETS-1:0] valid_q [WAYS];
  logic [SETS-1:0] dirty_q [WAYS];
  // lru_q[set] names the least recently used way
  logic [SETS-1:0] lru_q;

  // victim as a way number, selects tag and dirty bit
  logic victim_idx;

  // --------------------------------------
  // hit compare
  // --------------------------------------
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      hit_way[w] = valid_q[w][index] && (tag_mem[w][index] == tag);
    end
  end

  // --------------------------------------
  // victim choice
  // --------------------------------------
  // an empty way first, lru way only when the set is full
  always_comb begin
    if (!valid_q[0][index]) begin
      victim_way = 2'b01;
    end else if (!valid_q[1][index]) begin
      victim_way = 2'b10;
    end else begin
      victim_way = lru_q[index] ? 2'b10 : 2'b01;
    end
    victim_idx = victim_way[1];
    victim_tag = tag_mem[victim_idx][index];
    // only a valid line can need a write-back
    victim_dirty = valid_q[victim_idx][index] && dirty_q[victim_idx][index];
  end

  // --------------------------------------
  // status update
  // --------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      lru_q <= '0;
    end else if (|tag_write) begin
      // line fill, new tag in the victim way
      for (int w = 0; w < WAYS; w++) begin
        if (tag_write[w]) begin
          valid_q[w][index] <= 1'b1;
          // write-allocate fill is dirty straight away
          dirty_q[w][index] <= dirty_set;
        end
      end
      // filled way is now most recent
      lru_q[index] <= tag_write[0];
    end else if (hit_update) begin
      for (int w = 0; w < WAYS; w++) begin
        if (hit_way[w] && dirty_set) begin
          dirty_q[w][index] <= 1'b1;
        end
      end
      // point away from the hit way
      lru_q[index] <= hit_way[0];
    end
  end

  // tag array
  always_ff @(posedge clk) begin
    for (int w = 0; w < WAYS; w++) begin
      if (tag_write[w]) begin
        tag_mem[w][index] <= tag;
      end
    end
  end

  // --------------------------------------
  // checks
  // --------------------------------------
  // a tag lives in at most one way of a set
  a_hit_onehot : assert property (@(posedge clk) disable iff (reset)
    !(&hit_way));

  // the request that caused the fill hits the filled way right after
  a_fill_hits : assert property (@(posedge clk) disable iff (reset)
    (|tag_write) |=> (hit_way == $past(tag_write)));

endmodule

// File: testbench/cache_tb.sv
module cache_tb;

  import cache_pkg::*;

  localparam int IDX_BITS = 4;
  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 16;
  // generous bound for one request with a slow memory
  localparam int OP_CYCLES = 80;
  localparam int MAX_OPS = 32;
  localparam int LINE_OFS = OFFSET_BITS + BYTE_BITS;
  // untouched memory word = word address ^ this
  localparam word_t MEM_SALT = 32'hc0de_0000;

  logic clk;
  logic reset;
  addr_t a;
  be_t be;
  logic read;
  logic write;
  word_t wd;
  word_t rd;
  logic rd_valid;
  logic ready;
  addr_t mm_a;
  logic mm_read;
  logic mm_write;
  line_t mm_writedata;
  line_t mm_readdata;
  logic mm_readdata_valid;
  logic mm_ready;

  // operation table
  bit op_write [MAX_OPS];
  addr_t op_addr [MAX_OPS];
  be_t op_be [MAX_OPS];
  word_t op_data [MAX_OPS];
  int op_fills [MAX_OPS];
  int op_wbs [MAX_OPS];
  addr_t op_wb_addr [MAX_OPS];
  string op_name [MAX_OPS];
  int n_ops;

  // expected word content keyed by word-aligned byte address
  word_t ref_mem [addr_t];
  // lines the cache wrote back keyed by line address
  line_t mem_lines [addr_t];

  int cur_op;
  int fill_count;
  int wb_count;
  logic [31:0] lfsr = 32'h3271_5b11;

  cache_top #(
    .IDX_BITS(IDX_BITS)
  ) dut (
    .clk              (clk),
    .reset            (reset),
    .a                (a),
    .be               (be),
    .read             (read),
    .write            (write),
    .wd               (wd),
    .rd               (rd),
    .rd_valid         (rd_valid),
    .ready            (ready),
    .mm_a             (mm_a),
    .mm_read          (mm_read),
    .mm_write         (mm_write),
    .mm_writedata     (mm_writedata),
    .mm_readdata      (mm_readdata),
    .mm_readdata_valid(mm_readdata_valid),
    .mm_ready         (mm_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // error stop and compare tasks
  // ----------------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error: %s rd expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error: %s mm_a expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_line(input string name, input line_t exp, input line_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error: %s line expected %h actual %h", name, exp, act));
    end
  endtask

  // memory command counts per operation
  task automatic check_count(input string name, input string what, input int exp,
                             input int act);
    if (act != exp) begin
      stop_on_error($sformatf("Error: %s %s expected %0d actual %0d", name, what, exp, act));
    end
  endtask

  // ----------------------------------------
  // random bits and reference memory
  // ----------------------------------------
  // galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // one step per bit taken
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr[0]);
      lfsr = next_lfsr(lfsr);
    end
  endtask

  function automatic word_t default_word(input addr_t addr);
    return word_t'(addr >> BYTE_BITS) ^ MEM_SALT;
  endfunction

  function automatic word_t ref_word(input addr_t addr);
    addr_t key;
    key = (addr >> BYTE_BITS) << BYTE_BITS;
    if (ref_mem.exists(key)) begin
      return ref_mem[key];
    end
    return default_word(key);
  endfunction

  // byte-enable merge into the expected word
  task automatic ref_write(input addr_t addr, input be_t wbe, input word_t data);
    word_t w;
    addr_t key;
    key = (addr >> BYTE_BITS) << BYTE_BITS;
    w = ref_word(key);
    for (int b = 0; b < WORD_BITS / 8; b++) begin
      if (wbe[b]) begin
        w[b * 8 +: 8] = data[b * 8 +: 8];
      end
    end
    ref_mem[key] = w;
  endtask

  function automatic line_t ref_line(input addr_t addr);
    line_t l;
    addr_t base;
    base = (addr >> LINE_OFS) << LINE_OFS;
    for (int i = 0; i < LINE_WORDS; i++) begin
      l[i * WORD_BITS +: WORD_BITS] = ref_word(base + addr_t'(4 * i));
    end
    return l;
  endfunction

  // memory content is the written-back line or the address pattern
  function automatic line_t model_line(input addr_t addr);
    line_t l;
    addr_t base;
    base = (addr >> LINE_OFS) << LINE_OFS;
    if (mem_lines.exists(base)) begin
      return mem_lines[base];
    end
    for (int i = 0; i < LINE_WORDS; i++) begin
      l[i * WORD_BITS +: WORD_BITS] = default_word(base + addr_t'(4 * i));
    end
    return l;
  endfunction

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  initial begin
    mm_ready = 1'b1;
    mm_readdata_valid = 1'b0;
    mm_readdata = '0;
  end

  always @(posedge clk) begin : memory_model
    bit fill_busy;
    int fill_wait;
    int r;
    addr_t fill_addr;
    if (reset) begin
      fill_busy = 1'b0;
      mm_ready <= 1'b1;
      mm_readdata_valid <= 1'b0;
    end else begin
      mm_readdata_valid <= 1'b0;
      // evicted line must match the expected content
      if (mm_write) begin
        wb_count++;
        if (op_wbs[cur_op] != 0) begin
          check_addr(op_name[cur_op], op_wb_addr[cur_op], mm_a);
        end
        check_line(op_name[cur_op], ref_line(mm_a), mm_writedata);
        mem_lines[mm_a] = mm_writedata;
      end
      if (mm_read) begin
        fill_count++;
        fill_busy = 1'b1;
        fill_addr = mm_a;
        take_bits(3, fill_wait);
      end else if (fill_busy) begin
        if (fill_wait == 0) begin
          mm_readdata <= model_line(fill_addr);
          mm_readdata_valid <= 1'b1;
          fill_busy = 1'b0;
        end else begin
          fill_wait--;
        end
      end
      // low about one cycle in four
      take_bits(2, r);
      mm_ready <= (r != 0);
    end
  end

  // ----------------------------------------
  // operation table
  // ----------------------------------------
  task automatic add_op(input bit w, input addr_t ad, input be_t b, input word_t d,
                        input int f, input int wb, input addr_t wa, input string nm);
    op_write[n_ops] = w;
    op_addr[n_ops] = ad;
    op_be[n_ops] = b;
    op_data[n_ops] = d;
    op_fills[n_ops] = f;
    op_wbs[n_ops] = wb;
    op_wb_addr[n_ops] = wa;
    op_name[n_ops] = nm;
    n_ops++;
  endtask

  task automatic build_table();
    n_ops = 0;
    // line fill then hits in set 2
    add_op(1'b0, 32'h0000_1040, 4'hf, 32'h0, 1, 0, 32'h0, "first_read_miss");
    add_op(1'b0, 32'h0000_1044, 4'hf, 32'h0, 0, 0, 32'h0, "same_line_hit");
    add_op(1'b0, 32'h0000_105c, 4'hf, 32'h0, 0, 0, 32'h0, "same_line_hit_last");
    add_op(1'b1, 32'h0000_1048, 4'h5, 32'hdead_beef, 0, 0, 32'h0, "write_hit_partial");
    add_op(1'b0, 32'h0000_1048, 4'hf, 32'h0, 0, 0, 32'h0, "read_after_write_hit");
    // write-allocate in set 4
    add_op(1'b1, 32'h0000_2084, 4'hc, 32'h1234_5678, 1, 0, 32'h0, "write_miss");
    add_op(1'b0, 32'h0000_2084, 4'hf, 32'h0, 0, 0, 32'h0, "read_after_write_miss");
    add_op(1'b0, 32'h0000_2088, 4'hf, 32'h0, 0, 0, 32'h0, "write_miss_line_other");
    // third tag in set 2 evicts the dirty lru line
    add_op(1'b0, 32'h0000_1240, 4'hf, 32'h0, 1, 0, 32'h0, "second_tag");
    add_op(1'b0, 32'h0000_1440, 4'hf, 32'h0, 1, 1, 32'h0000_1040, "third_tag_evict");
    add_op(1'b0, 32'h0000_1048, 4'hf, 32'h0, 1, 0, 32'h0, "evicted_reread");
    // more traffic under random memory timing
    add_op(1'b0, 32'h0000_3000, 4'hf, 32'h0, 1, 0, 32'h0, "timing_set0_miss");
    add_op(1'b0, 32'h0000_3124, 4'hf, 32'h0, 1, 0, 32'h0, "timing_set9_miss");
    add_op(1'b0, 32'h0000_33e8, 4'hf, 32'h0, 1, 0, 32'h0, "timing_set15_miss");
    add_op(1'b0, 32'h0000_3004, 4'hf, 32'h0, 0, 0, 32'h0, "timing_set0_hit");
    add_op(1'b0, 32'h0000_5000, 4'hf, 32'h0, 1, 0, 32'h0, "timing_set0_way1");
    add_op(1'b0, 32'h0000_7000, 4'hf, 32'h0, 1, 0, 32'h0, "timing_set0_clean_evict");
    add_op(1'b1, 32'h0000_3128, 4'hf, 32'h0bad_f00d, 0, 0, 32'h0, "timing_write_full");
    add_op(1'b0, 32'h0000_3128, 4'hf, 32'h0, 0, 0, 32'h0, "timing_read_full");
    add_op(1'b0, 32'h0000_4084, 4'hf, 32'h0, 1, 0, 32'h0, "timing_set4_way1");
    add_op(1'b0, 32'h0000_6084, 4'hf, 32'h0, 1, 1, 32'h0000_2080, "timing_set4_evict");
    add_op(1'b0, 32'h0000_2084, 4'hf, 32'h0, 1, 0, 32'h0, "timing_set4_reread");
  endtask

  // ----------------------------------------
  // one request issued in an idle cycle
  // ----------------------------------------
  task automatic run_op(input int i);
    word_t exp;
    cur_op = i;
    fill_count = 0;
    wb_count = 0;
    @(negedge clk);
    while (!ready) @(negedge clk);
    // ready stays high until this strobe is taken
    @(posedge clk);
    a <= op_addr[i];
    be <= op_be[i];
    wd <= op_data[i];
    read <= !op_write[i];
    write <= op_write[i];
    @(posedge clk);
    read <= 1'b0;
    write <= 1'b0;
    if (op_write[i]) begin
      ref_write(op_addr[i], op_be[i], op_data[i]);
      // the cycle where ready returns is looked at too
      do begin
        @(negedge clk);
        if (rd_valid) begin
          stop_on_error($sformatf("rd_valid pulsed during write %s", op_name[i]));
        end
      end while (!ready);
    end else begin
      exp = ref_word(op_addr[i]);
      @(negedge clk);
      while (!rd_valid) @(negedge clk);
      check_word(op_name[i], exp, rd);
    end
    check_count(op_name[i], "fills", op_fills[i], fill_count);
    check_count(op_name[i], "write-backs", op_wbs[i], wb_count);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    reset = 1'b1;
    read = 1'b0;
    write = 1'b0;
    a = '0;
    be = '0;
    wd = '0;
    cur_op = 0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (ready !== 1'b1) begin
      stop_on_error("ready is not high after reset");
    end
    if (rd_valid !== 1'b0 || mm_read !== 1'b0 || mm_write !== 1'b0) begin
      stop_on_error("rd_valid, mm_read or mm_write is not low after reset");
    end
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    #1;
    #((n_ops * OP_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD);
    stop_on_error("timeout, the cache stopped answering requests");
  end

endmodule

// File: vlog.f
logic/cache_pkg.sv
logic/tag_store.sv
logic/data_store.sv
logic/cache_ctrl.sv
logic/cache_top.sv
testbench/cache_tb.sv
